// File: design/mac_pkg.sv
`default_nettype none

package mac_pkg;

  // Lane geometry
  localparam int NUM_BLOCKS    = 4;              // One block per byte of B
  localparam int BYTE_W        = 8;
  localparam int WORD_W        = NUM_BLOCKS * BYTE_W;
  localparam int ACC_W         = 64;             // Holds one full 32x32 product
  localparam int SINGLE_LANE_W = 2 * BYTE_W;     // 8x8 product per lane
  localparam int DUAL_LANE_W   = 4 * BYTE_W;     // 16x16 product per lane

  // Operand precision, mode 3 is reserved
  typedef enum logic [1:0] {
    MODE_SINGLE = 2'd0,  // Four 8-bit lanes
    MODE_DUAL   = 2'd1,  // Two 16-bit lanes
    MODE_QUAD   = 2'd2   // One 32-bit lane
  } mac_mode_t;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ACC_W-1:0]  acc_t;  // Partial product or accumulator

endpackage

`default_nettype wire

// File: design/mac_operand_if.sv
`timescale 1ns/10ps
`default_nettype none

// Registered operands from the feeder to the partial-product blocks and the accumulator
interface mac_operand_if (
  input logic clk
);
  import mac_pkg::*;

  word_t     a_q;
  word_t     b_q;
  mac_mode_t mode_q;
  logic      valid_q;  // One pulse per accepted sample
  logic      clr_q;    // Only meaningful together with valid_q

  modport src (output a_q, b_q, mode_q, valid_q, clr_q);

  // The blocks are combinational, clk is only there for their checks
  modport mul (input clk, a_q, b_q, mode_q, valid_q);

  modport acc (input mode_q, valid_q, clr_q);

endinterface

`default_nettype wire

// File: design/operand_stage.sv
`timescale 1ns/10ps
`default_nettype none

module operand_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  logic               clr,
  input  mac_pkg::mac_mode_t mode,
  input  mac_pkg::word_t     a,
  input  mac_pkg::word_t     b,
  mac_operand_if.src         opnd
);
  import mac_pkg::*;

  // Strobes follow en every cycle so they never stretch
  always_ff @(posedge clk) begin
    if (rst) begin
      opnd.valid_q <= 1'b0;
      opnd.clr_q   <= 1'b0;
      opnd.mode_q  <= MODE_SINGLE;
    end else begin
      opnd.valid_q <= en;
      opnd.clr_q   <= en & clr;
      if (en) begin
        opnd.mode_q <= mode;  // Held until the next sample
      end
    end
  end

  // Operand words only move on a sample
  always_ff @(posedge clk) begin
    if (en) begin
      opnd.a_q <= a;
      opnd.b_q <= b;
    end
  end

  // Reserved mode must never be sampled
  a_mode_legal: assert property (
    @(posedge clk) disable iff (rst)
    en |-> (mode inside {MODE_SINGLE, MODE_DUAL, MODE_QUAD})
  ) else $error("operand_stage: reserved mode %0d sampled", mode);

endmodule

`default_nettype wire

// File: design/mac_mul_block.sv
`timescale 1ns/10ps
`default_nettype none

// Multiplies byte BLOCK_IDX of B by the A slice of its lane and aligns the result
module mac_mul_block #(
  parameter int BLOCK_IDX = 0  // Byte of B, 0 to 3
) (
  mac_operand_if.mul    opnd,
  output mac_pkg::acc_t partial
);
  import mac_pkg::*;

  localparam int DUAL_LANE = BLOCK_IDX / 2;  // Halfword lane this byte belongs to

  byte_t                      b_byte;
  byte_t                      a_byte;
  logic [SINGLE_LANE_W-1:0]   a_half;
  logic [2*BYTE_W-1:0]        prod_single;  // 8x8
  logic [3*BYTE_W-1:0]        prod_dual;    // 16x8
  logic [WORD_W+BYTE_W-1:0]   prod_quad;    // 32x8
  acc_t                       lane_mask;

  assign b_byte = opnd.b_q[BYTE_W*BLOCK_IDX +: BYTE_W];
  assign a_byte = opnd.a_q[BYTE_W*BLOCK_IDX +: BYTE_W];
  assign a_half = opnd.a_q[SINGLE_LANE_W*DUAL_LANE +: SINGLE_LANE_W];

  assign prod_single = a_byte * b_byte;
  assign prod_dual   = a_half * b_byte;
  assign prod_quad   = opnd.a_q * b_byte;

  always_comb begin
    case (opnd.mode_q)
      MODE_SINGLE: begin
        partial   = acc_t'(prod_single) << (SINGLE_LANE_W * BLOCK_IDX);
        lane_mask = acc_t'({SINGLE_LANE_W{1'b1}}) << (SINGLE_LANE_W * BLOCK_IDX);
      end
      MODE_DUAL: begin
        // Byte weight within the halfword, then the lane offset on top
        partial   = acc_t'(prod_dual) << (BYTE_W * BLOCK_IDX + SINGLE_LANE_W * DUAL_LANE);
        lane_mask = acc_t'({DUAL_LANE_W{1'b1}}) << (DUAL_LANE_W * DUAL_LANE);
      end
      MODE_QUAD: begin
        partial   = acc_t'(prod_quad) << (BYTE_W * BLOCK_IDX);
        lane_mask = '1;
      end
      default: begin
        partial   = '0;  // Reserved mode contributes nothing
        lane_mask = '0;
      end
    endcase
  end

  // A partial that leaks past its lane would corrupt the neighbor lane
  a_partial_in_lane: assert property (
    @(posedge opnd.clk)
    opnd.valid_q |-> ((partial & ~lane_mask) == '0)
  ) else $error("mac_mul_block %0d: partial %h outside lane", BLOCK_IDX, partial);

endmodule

`default_nettype wire

// File: design/lane_accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module lane_accumulator (
  input  logic          clk,
  input  logic          rst,
  mac_operand_if.acc    opnd,
  input  mac_pkg::acc_t partials [mac_pkg::NUM_BLOCKS],
  output mac_pkg::acc_t acc,
  output logic          acc_valid
);
  import mac_pkg::*;

  localparam int NUM_SEG = ACC_W / SINGLE_LANE_W;  // Narrowest lane is one segment

  acc_t               prod_sum;
  acc_t               acc_base;
  acc_t               acc_next;
  logic [NUM_SEG-1:0] seg_kill;  // Carry into segment s is blocked

  // Each lane's partials add up to its exact product, so no carry leaves a lane
  always_comb begin
    prod_sum = '0;
    for (int i = 0; i < NUM_BLOCKS; i++) begin
      prod_sum = prod_sum + partials[i];
    end
  end

  assign acc_base = opnd.clr_q ? '0 : acc;  // Clear turns the add into a load

  // Lane boundaries as seen at each segment edge
  always_comb begin
    for (int s = 0; s < NUM_SEG; s++) begin
      case (opnd.mode_q)
        MODE_DUAL: seg_kill[s] = ((s * SINGLE_LANE_W) % DUAL_LANE_W) == 0;
        MODE_QUAD: seg_kill[s] = (s == 0);
        default:   seg_kill[s] = 1'b1;
      endcase
    end
  end

  // Segmented adder with the carry dropped at each lane edge
  always_comb begin
    logic [SINGLE_LANE_W:0] seg_sum;
    logic                   carry;
    carry = 1'b0;
    for (int s = 0; s < NUM_SEG; s++) begin
      seg_sum = {1'b0, acc_base[s*SINGLE_LANE_W +: SINGLE_LANE_W]}
              + {1'b0, prod_sum[s*SINGLE_LANE_W +: SINGLE_LANE_W]}
              + (carry & ~seg_kill[s]);
      acc_next[s*SINGLE_LANE_W +: SINGLE_LANE_W] = seg_sum[SINGLE_LANE_W-1:0];
      carry = seg_sum[SINGLE_LANE_W];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      acc       <= '0;
      acc_valid <= 1'b0;
    end else begin
      acc_valid <= opnd.valid_q;
      if (opnd.valid_q) begin
        acc <= acc_next;
      end
    end
  end

  // Output strobe is the sample strobe delayed once
  a_valid_follows: assert property (
    @(posedge clk) disable iff (rst)
    acc_valid |-> $past(opnd.valid_q)
  ) else $error("lane_accumulator: acc_valid without a sample");

endmodule

`default_nettype wire

// File: design/mac_unit.sv
`timescale 1ns/10ps
`default_nettype none

// Precision-scalable MAC, two cycles from the en edge to the acc update
module mac_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               en,
  input  logic               clr,
  input  mac_pkg::mac_mode_t mode,
  input  mac_pkg::word_t     a,
  input  mac_pkg::word_t     b,
  output mac_pkg::acc_t      acc,
  output logic               acc_valid
);
  import mac_pkg::*;

  acc_t partials [NUM_BLOCKS];  // One per byte of B

  mac_operand_if u_opnd_if (
    .clk (clk)
  );

  operand_stage u_operand_stage (
    .clk  (clk),
    .rst  (rst),
    .en   (en),
    .clr  (clr),
    .mode (mode),
    .a    (a),
    .b    (b),
    .opnd (u_opnd_if)
  );

  for (genvar i = 0; i < NUM_BLOCKS; i++) begin : g_mul
    mac_mul_block #(
      .BLOCK_IDX (i)
    ) u_mul_block (
      .opnd    (u_opnd_if),
      .partial (partials[i])
    );
  end

  lane_accumulator u_lane_accumulator (
    .clk       (clk),
    .rst       (rst),
    .opnd      (u_opnd_if),
    .partials  (partials),
    .acc       (acc),
    .acc_valid (acc_valid)
  );

endmodule

`default_nettype wire

// File: dv/mac_model.svh
`ifndef MAC_MODEL_SVH
`define MAC_MODEL_SVH

// Expected accumulator after one sample, built lane by lane from the lane rule
function automatic acc_t model_mac(input acc_t acc_old, input mac_mode_t m,
                                   input logic clr_v, input word_t av, input word_t bv);
  int   in_w;
  int   lanes;
  acc_t in_mask;
  acc_t lane_mask;
  acc_t prod;
  acc_t lane_val;
  acc_t result;
  case (m)
    MODE_DUAL: in_w = 16;
    MODE_QUAD: in_w = 32;
    default:   in_w = 8;
  endcase
  lanes     = 32 / in_w;
  in_mask   = (64'd1 << in_w) - 64'd1;
  lane_mask = (in_w == 32) ? '1 : (64'd1 << (2 * in_w)) - 64'd1;  // Lane is twice the slice
  result    = '0;
  for (int k = 0; k < lanes; k++) begin
    prod     = ((acc_t'(av) >> (k * in_w)) & in_mask) * ((acc_t'(bv) >> (k * in_w)) & in_mask);
    lane_val = (acc_old >> (k * 2 * in_w)) & lane_mask;
    lane_val = clr_v ? prod : lane_val + prod;
    result   = result | ((lane_val & lane_mask) << (k * 2 * in_w));  // Wrap inside the lane
  end
  return result;
endfunction

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

`endif

// File: dv/mac_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mac_unit_tb;
  import mac_pkg::*;

  `include "mac_model.svh"

  typedef struct packed {
    logic [2:0] test_id;
    logic       en;
    logic       clr;
    mac_mode_t  mode;
    word_t      a;
    word_t      b;
  } row_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      en;
  logic      clr;
  mac_mode_t mode;
  word_t     a;
  word_t     b;
  acc_t      acc;
  logic      acc_valid;

  row_t        table_q [$];
  logic        exp_valid_q [$];
  acc_t        exp_acc_q [$];
  int          exp_test_q [$];
  acc_t        model_acc;
  logic [15:0] lfsr_q;
  int          cur_test = 1;
  int          test_checks = 0;
  int          test_errors = 0;
  int          test_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;

  mac_unit u_dut (
    .clk       (clk),
    .rst       (rst),
    .en        (en),
    .clr       (clr),
    .mode      (mode),
    .a         (a),
    .b         (b),
    .acc       (acc),
    .acc_valid (acc_valid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) cycle_count <= cycle_count + 1;

  // One bit per LFSR step
  function automatic word_t rand_word();
    word_t w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w      = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic void add_row(input int t, input logic en_v, input logic clr_v,
                                  input mac_mode_t m, input word_t av, input word_t bv);
    row_t r;
    r.test_id = 3'(t);
    r.en      = en_v;
    r.clr     = clr_v;
    r.mode    = m;
    r.a       = av;
    r.b       = bv;
    table_q.push_back(r);
  endfunction

  function automatic void build_table();
    repeat (3) add_row(1, 1'b0, 1'b0, MODE_SINGLE, '0, '0);  // Idle after reset
    add_row(2, 1'b1, 1'b1, MODE_SINGLE, 32'h03FF_FFFF, 32'h07FF_FFFF);
    add_row(2, 1'b1, 1'b0, MODE_SINGLE, 32'h0107_0707, 32'h0149_4949);  // Lanes 0 to 2 wrap to 0
    repeat (2) add_row(2, 1'b1, 1'b0, MODE_SINGLE, rand_word(), rand_word());
    add_row(3, 1'b1, 1'b1, MODE_DUAL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_row(3, 1'b1, 1'b0, MODE_DUAL, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_row(3, 1'b1, 1'b0, MODE_DUAL, 32'h0001_FFFF, 32'h0001_0002);
    repeat (2) add_row(3, 1'b1, 1'b0, MODE_DUAL, rand_word(), rand_word());
    add_row(4, 1'b1, 1'b1, MODE_QUAD, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    repeat (4) add_row(4, 1'b1, 1'b0, MODE_QUAD, rand_word(), rand_word());
    add_row(4, 1'b1, 1'b0, MODE_QUAD, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_row(5, 1'b1, 1'b1, MODE_SINGLE, rand_word(), rand_word());
    add_row(5, 1'b1, 1'b1, MODE_DUAL, rand_word(), rand_word());
    add_row(5, 1'b0, 1'b0, MODE_SINGLE, '0, '0);
    add_row(5, 1'b1, 1'b1, MODE_QUAD, rand_word(), rand_word());
    repeat (2) add_row(5, 1'b0, 1'b0, MODE_SINGLE, '0, '0);
    add_row(5, 1'b1, 1'b1, MODE_SINGLE, rand_word(), rand_word());
    add_row(5, 1'b1, 1'b1, MODE_QUAD, rand_word(), rand_word());
    add_row(5, 1'b1, 1'b1, MODE_DUAL, rand_word(), rand_word());
  endfunction

  function automatic string test_name(input int id);
    case (id)
      1:       return "reset idle";
      2:       return "single lanes";
      3:       return "dual lanes";
      4:       return "quad lane";
      default: return "back-to-back";
    endcase
  endfunction

  task automatic report_test(input int id);
    test_count++;
    $display("test %0d %s: %0d checks, %0d errors", id, test_name(id), test_checks, test_errors);
  endtask

  task automatic drive_row(input row_t r);
    en   <= r.en;
    clr  <= r.clr;
    mode <= r.mode;
    a    <= r.a;
    b    <= r.b;
  endtask

  // Compares against the sample driven two edges earlier
  task automatic check_outputs();
    logic exp_v;
    acc_t exp_a;
    int   t;
    exp_v = exp_valid_q.pop_front();
    exp_a = exp_acc_q.pop_front();
    t     = exp_test_q.pop_front();
    if (t != cur_test) begin
      report_test(cur_test);
      cur_test    = t;
      test_checks = 0;
      test_errors = 0;
    end
    test_checks++;
    check_count++;
    assert (acc_valid === exp_v) else begin
      $display("** Error acc_valid: got 0x%h expected 0x%h (test %0d)", acc_valid, exp_v, t);
      test_errors++;
      error_count++;
    end
    assert (acc === exp_a) else begin
      $display("** Error acc: got 0x%h expected 0x%h (test %0d)", acc, exp_a, t);
      test_errors++;
      error_count++;
    end
  endtask

  initial begin : main
    row_t row;
    rst       = 1'b1;
    en        = 1'b0;
    clr       = 1'b0;
    mode      = MODE_SINGLE;
    a         = '0;
    b         = '0;
    lfsr_q    = 16'd46316;
    model_acc = '0;
    build_table();
    cycle_limit = table_q.size() + 20;
    repeat (2) begin  // Pipeline is empty for the first two checks
      exp_valid_q.push_back(1'b0);
      exp_acc_q.push_back('0);
      exp_test_q.push_back(1);
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int c = 0; c < table_q.size() + 2; c++) begin
      @(posedge clk);
      if (c < table_q.size()) begin
        row = table_q[c];
      end else begin
        row         = '0;  // Drain cycles
        row.test_id = table_q[table_q.size()-1].test_id;
      end
      drive_row(row);
      if (row.en) model_acc = model_mac(model_acc, row.mode, row.clr, row.a, row.b);
      exp_valid_q.push_back(row.en);
      exp_acc_q.push_back(model_acc);
      exp_test_q.push_back(int'(row.test_id));
      @(negedge clk);
      check_outputs();
    end
    report_test(cur_test);
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    wait (cycle_limit > 0);
    wait (cycle_count >= cycle_limit);
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+dv
design/mac_pkg.sv
design/mac_operand_if.sv
design/operand_stage.sv
design/mac_mul_block.sv
design/lane_accumulator.sv
design/mac_unit.sv
dv/mac_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mac_unit_tb -f build.f -o mac_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

sim_out=$(./obj_dir/mac_sim)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if printf '%s\n' "$sim_out" | grep -qx "RESULT: PASS"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
